// File: Makefile
# Verilator build for the mobility evaluator testbench

VERILATOR ?= verilator
TOP       ?= tb_mobility_eval
FILELIST  ?= mobility_eval.f
BUILD_DIR ?= build
FLAGS     ?= -j 0

BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# Output goes to the terminal and the search decides the exit status
run: compile
	@out="$$($(BINARY))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Regression passed'

clean:
	rm -rf $(BUILD_DIR)

// File: bench/mobility_checker.sv
////////////////////////////////////////////////////////////////////////////
// Mobility evaluator checker with a ray-walking reference model
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mobility_checker
(
   input  logic                                        clk,
   input  logic                                        rst_n,
   input  logic                                        req,
   input  logic [mobility_pkg::BOARD_BITS-1:0]         board,
   input  logic [5:0]                                  square,
   input  logic                                        ack,
   input  logic [mobility_pkg::COUNT_BITS-1:0]         mobility,
   input  logic signed [mobility_pkg::EVAL_BITS-1:0]   eval_mg,
   input  logic signed [mobility_pkg::EVAL_BITS-1:0]   eval_eg,
   input  logic [8*24-1:0]                             test_name,
   output int                                          checked,
   output int                                          errors
);

   logic [mobility_pkg::BOARD_BITS-1:0]       cap_board;   // Board seen with req
   int                                        cap_square;
   int                                        cyc;
   int                                        req_cyc;
   int                                        req_low_cyc;
   logic                                      req_q;
   logic                                      ack_q;
   bit                                        reset_seen;
   bit                                        ok;
   int                                        exp_cnt;
   logic [mobility_pkg::COUNT_BITS-1:0]       held_mob;
   logic signed [mobility_pkg::EVAL_BITS-1:0] held_mg;
   logic signed [mobility_pkg::EVAL_BITS-1:0] held_eg;

   // Walk every legal direction until the edge or the first piece
   function automatic int count_moves(input logic [mobility_pkg::BOARD_BITS-1:0] b,
                                      input int sq);
      int                        r;
      int                        c;
      int                        dr;
      int                        dc;
      int                        n;
      logic [3:0]                own;
      logic [3:0]                here;
      mobility_pkg::piece_kind_t kind;
      bit                        diag;
      bit                        use_dir;
      bit                        live;
      own  = b[sq*4 +: 4];
      kind = mobility_pkg::piece_kind_t'(own[2:0]);
      n    = 0;
      for (dr = -1; dr <= 1; dr++)
      begin
         for (dc = -1; dc <= 1; dc++)
         begin
            diag    = (dr != 0) && (dc != 0);
            use_dir = diag ? (kind == mobility_pkg::BISHOP || kind == mobility_pkg::QUEEN)
                           : (kind == mobility_pkg::ROOK || kind == mobility_pkg::QUEEN);
            if ((dr != 0 || dc != 0) && use_dir)
            begin
               r    = sq / 8 + dr;
               c    = sq % 8 + dc;
               live = 1'b1;
               while (live && r >= 0 && r < 8 && c >= 0 && c < 8)
               begin
                  here = b[(r*8 + c)*4 +: 4];
                  if (here == 4'd0)
                     n++;
                  else
                  begin
                     if (here[3] != own[3])
                        n++;   // Enemy piece can be taken
                     live = 1'b0;
                  end
                  r += dr;
                  c += dc;
               end
            end
         end
      end
      return n;
   endfunction

   function automatic int apply_score(input mobility_pkg::piece_kind_t kind, input logic black,
                                      input int cnt, input bit endgame);
      int step;
      int base;
      int s;
      step = 0;
      base = 0;
      case (kind)
         mobility_pkg::BISHOP:
         begin
            step = endgame ? int'(mobility_pkg::BISHOP_EG_STEP) : int'(mobility_pkg::BISHOP_MG_STEP);
            base = endgame ? int'(mobility_pkg::BISHOP_EG_BASE) : int'(mobility_pkg::BISHOP_MG_BASE);
         end
         mobility_pkg::ROOK:
         begin
            step = endgame ? int'(mobility_pkg::ROOK_EG_STEP) : int'(mobility_pkg::ROOK_MG_STEP);
            base = endgame ? int'(mobility_pkg::ROOK_EG_BASE) : int'(mobility_pkg::ROOK_MG_BASE);
         end
         mobility_pkg::QUEEN:
         begin
            step = endgame ? int'(mobility_pkg::QUEEN_EG_STEP) : int'(mobility_pkg::QUEEN_MG_STEP);
            base = endgame ? int'(mobility_pkg::QUEEN_EG_BASE) : int'(mobility_pkg::QUEEN_MG_BASE);
         end
         default: ;
      endcase
      s = step * cnt - base;
      return black ? -s : s;
   endfunction

   task automatic check_value(input logic [8*24-1:0] name, input string field,
                              input int expected, input int actual, inout bit pass);
      if (expected != actual)
      begin
         $display("[FAIL] %0s %0s expected %0d actual %0d", name, field, expected, actual);
         errors++;
         pass = 1'b0;
      end
   endtask

   // Monitor on the falling edge where DUT outputs are settled
   always @(negedge clk)
   begin
      if (!rst_n)
      begin
         checked    = 0;
         errors     = 0;
         cyc        = 0;
         req_q      = 1'b0;
         ack_q      = 1'b0;
         reset_seen = 1'b0;
      end
      else
      begin
         cyc++;
         if (!reset_seen)
         begin
            ok = 1'b1;
            check_value("reset_state", "ack", 0, int'(ack), ok);
            check_value("reset_state", "mobility", 0, int'(mobility), ok);
            check_value("reset_state", "eval_mg", 0, int'(eval_mg), ok);
            check_value("reset_state", "eval_eg", 0, int'(eval_eg), ok);
            if (ok)
               $display("[PASS] reset_state");
            reset_seen = 1'b1;
         end
         if (req && !req_q)
         begin
            cap_board  = board;
            cap_square = int'(square);
            req_cyc    = cyc;
         end
         if (ack && !ack_q)
         begin
            ok      = 1'b1;
            exp_cnt = count_moves(cap_board, cap_square);
            check_value(test_name, "ack latency", 4, cyc - req_cyc - 1, ok);
            check_value(test_name, "mobility", exp_cnt, int'(mobility), ok);
            check_value(test_name, "eval_mg",
                        apply_score(mobility_pkg::piece_kind_t'(cap_board[cap_square*4 +: 3]),
                                    cap_board[cap_square*4 + 3], exp_cnt, 1'b0),
                        int'(eval_mg), ok);
            check_value(test_name, "eval_eg",
                        apply_score(mobility_pkg::piece_kind_t'(cap_board[cap_square*4 +: 3]),
                                    cap_board[cap_square*4 + 3], exp_cnt, 1'b1),
                        int'(eval_eg), ok);
            if (ok)
               $display("[PASS] %0s mobility %0d mg %0d eg %0d", test_name, mobility,
                        eval_mg, eval_eg);
            held_mob = mobility;
            held_mg  = eval_mg;
            held_eg  = eval_eg;
            checked++;
         end
         if (ack && ack_q && (mobility != held_mob || eval_mg != held_mg || eval_eg != held_eg))
         begin
            $display("Results changed while ack was high in test %0s", test_name);
            errors++;
         end
         if (!req && req_q)
            req_low_cyc = cyc;
         if (!ack && ack_q)
         begin
            ok = 1'b1;
            check_value(test_name, "ack fall delay", 1, cyc - req_low_cyc, ok);
         end
         req_q = req;
         ack_q = ack;
      end
   end

endmodule

// File: bench/tb_mobility_eval.sv
////////////////////////////////////////////////////////////////////////////
// Mobility evaluator testbench with directed and random boards
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_mobility_eval;

   localparam int NAME_BITS = 8 * 24;
   localparam int TIMEOUT   = 50;   // Cycles per handshake wait

   logic                                      clk;
   logic                                      rst_n;
   logic                                      req;
   logic [mobility_pkg::BOARD_BITS-1:0]       board;
   logic [5:0]                                square;
   logic                                      ack;
   logic [mobility_pkg::COUNT_BITS-1:0]       mobility;
   logic signed [mobility_pkg::EVAL_BITS-1:0] eval_mg;
   logic signed [mobility_pkg::EVAL_BITS-1:0] eval_eg;

   logic [NAME_BITS-1:0]                      test_name;
   logic [NAME_BITS-1:0]                      name_buf;
   logic [mobility_pkg::BOARD_BITS-1:0]       board_buf;   // Board under construction
   logic [31:0]                               r;
   integer                                    seed;
   int                                        tests_run;
   int                                        checked;
   int                                        errors;
   int                                        k;
   int                                        v;
   bit                                        timed_out;

   mobility_eval i_dut
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (req),
      .board    (board),
      .square   (square),
      .ack      (ack),
      .mobility (mobility),
      .eval_mg  (eval_mg),
      .eval_eg  (eval_eg)
   );

   mobility_checker u_checker
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req),
      .board     (board),
      .square    (square),
      .ack       (ack),
      .mobility  (mobility),
      .eval_mg   (eval_mg),
      .eval_eg   (eval_eg),
      .test_name (test_name),
      .checked   (checked),
      .errors    (errors)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic put_piece(input int sq, input logic [3:0] code);
      board_buf[sq*4 +: 4] = code;
   endtask

   task automatic wait_ack(input logic level, output bit seen);
      int cnt;
      cnt = 0;
      do
      begin
         @(negedge clk);
         cnt++;
      end
      while (ack != level && cnt < TIMEOUT);
      seen = (ack == level);
   endtask

   // One full four-phase handshake on the board in board_buf
   task automatic run_test(input logic [NAME_BITS-1:0] name, input logic [5:0] sq);
      bit seen;
      if (!timed_out)
      begin
         @(posedge clk);
         test_name <= name;
         board     <= board_buf;
         square    <= sq;
         req       <= 1'b1;
         wait_ack(1'b1, seen);
         if (!seen)
         begin
            $display("Timeout in test %0s: ack never rose after req", name);
            timed_out = 1'b1;
         end
         else
         begin
            tests_run++;
            @(posedge clk);
            req <= 1'b0;
            wait_ack(1'b0, seen);
            if (!seen)
            begin
               $display("Timeout in test %0s: ack never fell after req dropped", name);
               timed_out = 1'b1;
            end
         end
      end
   endtask

   task automatic finish_run;
      $display("Tests run %0d, results checked %0d, errors %0d", tests_run, checked, errors);
      if (checked != tests_run)
         $display("Checker saw %0d results for %0d tests", checked, tests_run);
      if (errors == 0 && !timed_out && checked == tests_run)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   endtask

   initial
   begin
      seed      = 11914;
      tests_run = 0;
      timed_out = 1'b0;
      rst_n     = 1'b0;
      req       = 1'b0;
      board     = '0;
      square    = '0;
      test_name = '0;
      board_buf = '0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;

      board_buf = '0;
      put_piece(27, 4'h5);
      run_test("queen_center", 6'd27);
      board_buf = '0;
      put_piece(0, 4'h4);
      run_test("rook_corner", 6'd0);

      // Own pawns on every diagonal neighbour
      board_buf = '0;
      put_piece(27, 4'h3);
      put_piece(18, 4'h1);
      put_piece(20, 4'h1);
      put_piece(34, 4'h1);
      put_piece(36, 4'h1);
      run_test("bishop_boxed", 6'd27);
      board_buf = '0;
      put_piece(27, 4'hB);
      put_piece(18, 4'h9);
      put_piece(20, 4'h9);
      put_piece(34, 4'h9);
      put_piece(36, 4'h9);
      run_test("black_bishop_boxed", 6'd27);

      // Enemy pawns two squares out on each line
      board_buf = '0;
      put_piece(27, 4'h4);
      put_piece(11, 4'h9);
      put_piece(25, 4'h9);
      put_piece(29, 4'h9);
      put_piece(43, 4'h9);
      run_test("rook_captures", 6'd27);
      board_buf = '0;
      put_piece(27, 4'hC);
      put_piece(11, 4'h1);
      put_piece(25, 4'h1);
      put_piece(29, 4'h1);
      put_piece(43, 4'h1);
      run_test("black_rook_captures", 6'd27);
      board_buf = '0;
      put_piece(27, 4'hD);
      run_test("black_queen_center", 6'd27);

      board_buf = '0;
      put_piece(0, 4'h5);
      run_test("empty_square", 6'd27);
      board_buf = '0;
      put_piece(27, 4'h1);
      run_test("pawn_piece", 6'd27);
      board_buf = '0;
      put_piece(27, 4'h2);
      run_test("knight_piece", 6'd27);
      board_buf = '0;
      put_piece(27, 4'hE);
      run_test("king_piece", 6'd27);

      for (int n = 0; n < 200; n++)
      begin
         board_buf = '0;
         for (int i = 0; i < 64; i++)
         begin
            r = $random(seed);
            v = int'(r[9:0]);
            if (v % 3 == 0)   // Roughly one square in three
            begin
               k = 1 + (v / 3) % 6;
               put_piece(i, {r[12], k[2:0]});
            end
         end
         r = $random(seed);
         k = int'(r[15:8]) % 10;
         if (k < 6)
            k = 3 + k % 3;   // Sliders most of the time
         else if (k == 9)
            k = 6;
         else
            k = k - 6;
         put_piece(int'(r[5:0]), (k == 0) ? 4'h0 : {r[16], k[2:0]});
         $sformat(name_buf, "random_%0d", n);
         run_test(name_buf, r[5:0]);
      end

      repeat (2) @(posedge clk);
      finish_run;
   end

endmodule

// File: mobility_eval.f
verilog/mobility_pkg.sv
verilog/square_decode.sv
verilog/ray_mobility.sv
verilog/mobility_score.sv
verilog/mobility_eval.sv
bench/mobility_checker.sv
bench/tb_mobility_eval.sv

// File: verilog/mobility_eval.sv
////////////////////////////////////////////////////////////////////////////
// Mobility evaluator top: four-phase req/ack controller in front of
// the decode, ray-trace and score stages
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mobility_eval
(
   input  logic                                        clk,
   input  logic                                        rst_n,
   input  logic                                        req,
   input  logic [mobility_pkg::BOARD_BITS-1:0]         board,
   input  logic [5:0]                                  square,
   output logic                                        ack,
   output logic [mobility_pkg::COUNT_BITS-1:0]         mobility,
   output logic signed [mobility_pkg::EVAL_BITS-1:0]   eval_mg,
   output logic signed [mobility_pkg::EVAL_BITS-1:0]   eval_eg
);

   mobility_pkg::ctrl_state_t state;
   logic                      start;    // One pulse per accepted req

   logic                      dec_valid;
   mobility_pkg::piece_kind_t dec_kind;
   logic                      dec_black;
   logic [5:0]                dec_square;
   logic [63:0]               dec_occupied;
   logic [63:0]               dec_friendly;

   logic                      exe_valid;
   mobility_pkg::piece_kind_t exe_kind;
   logic                      exe_black;
   logic [63:0]               exe_reach;

   logic                      res_valid;

   // One item in flight, so the stages never see back-to-back starts
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state <= mobility_pkg::CTRL_IDLE;
         start <= 1'b0;
      end
      else
      begin
         start <= 1'b0;
         case (state)
            mobility_pkg::CTRL_IDLE:
               if (req)
               begin
                  state <= mobility_pkg::CTRL_BUSY;
                  start <= 1'b1;
               end
            mobility_pkg::CTRL_BUSY:
               if (res_valid)
                  state <= mobility_pkg::CTRL_ACK;   // Results now stable
            mobility_pkg::CTRL_ACK:
               if (!req)
                  state <= mobility_pkg::CTRL_IDLE;
            default: state <= mobility_pkg::CTRL_IDLE;
         endcase
      end
   end

   assign ack = (state == mobility_pkg::CTRL_ACK);

   square_decode u_decode
   (
      .clk, .rst_n, .start, .board, .square,
      .dec_valid, .dec_kind, .dec_black, .dec_square, .dec_occupied, .dec_friendly
   );

   ray_mobility u_execute
   (
      .clk, .rst_n, .dec_valid, .dec_kind, .dec_black, .dec_square, .dec_occupied,
      .dec_friendly, .exe_valid, .exe_kind, .exe_black, .exe_reach
   );

   mobility_score u_result
   (
      .clk, .rst_n, .exe_valid, .exe_kind, .exe_black, .exe_reach,
      .res_valid, .mobility, .eval_mg, .eval_eg
   );

endmodule

// File: verilog/mobility_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Sliding-piece mobility evaluator shared definitions
// Board format, piece kinds, score slopes and handshake states
////////////////////////////////////////////////////////////////////////////
package mobility_pkg;

   // Board format
   localparam int SQUARE_BITS = 4;                  // One square code
   localparam int BOARD_BITS  = 64 * SQUARE_BITS;   // Square n at bits n*4 upward
   localparam int BLACK_BIT   = 3;                  // Set means black

   // Low three bits of a square code
   typedef enum logic [2:0]
   {
      EMPTY  = 3'd0,
      PAWN   = 3'd1,
      KNIGHT = 3'd2,
      BISHOP = 3'd3,
      ROOK   = 3'd4,
      QUEEN  = 3'd5,
      KING   = 3'd6
   } piece_kind_t;

   // Result widths
   localparam int COUNT_BITS = 5;    // Queen tops out at 27
   localparam int EVAL_BITS  = 12;

   // Score is STEP * count - BASE, negated for black
   localparam logic signed [EVAL_BITS-1:0] BISHOP_MG_STEP = 12'sd6;
   localparam logic signed [EVAL_BITS-1:0] BISHOP_MG_BASE = 12'sd20;
   localparam logic signed [EVAL_BITS-1:0] BISHOP_EG_STEP = 12'sd8;
   localparam logic signed [EVAL_BITS-1:0] BISHOP_EG_BASE = 12'sd30;

   localparam logic signed [EVAL_BITS-1:0] ROOK_MG_STEP   = 12'sd3;
   localparam logic signed [EVAL_BITS-1:0] ROOK_MG_BASE   = 12'sd15;
   localparam logic signed [EVAL_BITS-1:0] ROOK_EG_STEP   = 12'sd9;
   localparam logic signed [EVAL_BITS-1:0] ROOK_EG_BASE   = 12'sd40;

   localparam logic signed [EVAL_BITS-1:0] QUEEN_MG_STEP  = 12'sd2;
   localparam logic signed [EVAL_BITS-1:0] QUEEN_MG_BASE  = 12'sd10;
   localparam logic signed [EVAL_BITS-1:0] QUEEN_EG_STEP  = 12'sd5;
   localparam logic signed [EVAL_BITS-1:0] QUEEN_EG_BASE  = 12'sd35;

   // Top-level req/ack controller
   typedef enum logic [1:0]
   {
      CTRL_IDLE = 2'd0,
      CTRL_BUSY = 2'd1,   // Item in the pipeline
      CTRL_ACK  = 2'd2    // Results held until req drops
   } ctrl_state_t;

endpackage

// File: verilog/mobility_score.sv
////////////////////////////////////////////////////////////////////////////
// Result stage: counts the reach mask and turns it into signed
// middle-game and end-game scores
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mobility_score
(
   input  logic                                        clk,
   input  logic                                        rst_n,
   input  logic                                        exe_valid,
   input  mobility_pkg::piece_kind_t                   exe_kind,
   input  logic                                        exe_black,
   input  logic [63:0]                                 exe_reach,
   output logic                                        res_valid,
   output logic [mobility_pkg::COUNT_BITS-1:0]         mobility,
   output logic signed [mobility_pkg::EVAL_BITS-1:0]   eval_mg,
   output logic signed [mobility_pkg::EVAL_BITS-1:0]   eval_eg
);

   logic [mobility_pkg::COUNT_BITS-1:0]       reach_count;
   logic signed [mobility_pkg::EVAL_BITS-1:0] count_ext;
   logic signed [mobility_pkg::EVAL_BITS-1:0] step_mg, base_mg;
   logic signed [mobility_pkg::EVAL_BITS-1:0] step_eg, base_eg;
   logic signed [mobility_pkg::EVAL_BITS-1:0] score_mg, score_eg;

   // Population count of the reach mask
   always_comb
   begin
      reach_count = '0;
      for (int i = 0; i < 64; i++)
         reach_count = reach_count + {{(mobility_pkg::COUNT_BITS-1){1'b0}}, exe_reach[i]};
   end

   assign count_ext = {{(mobility_pkg::EVAL_BITS - mobility_pkg::COUNT_BITS){1'b0}}, reach_count};

   always_comb
   begin
      step_mg = '0;   // Non-sliders score zero
      base_mg = '0;
      step_eg = '0;
      base_eg = '0;
      case (exe_kind)
         mobility_pkg::BISHOP:
         begin
            step_mg = mobility_pkg::BISHOP_MG_STEP;
            base_mg = mobility_pkg::BISHOP_MG_BASE;
            step_eg = mobility_pkg::BISHOP_EG_STEP;
            base_eg = mobility_pkg::BISHOP_EG_BASE;
         end
         mobility_pkg::ROOK:
         begin
            step_mg = mobility_pkg::ROOK_MG_STEP;
            base_mg = mobility_pkg::ROOK_MG_BASE;
            step_eg = mobility_pkg::ROOK_EG_STEP;
            base_eg = mobility_pkg::ROOK_EG_BASE;
         end
         mobility_pkg::QUEEN:
         begin
            step_mg = mobility_pkg::QUEEN_MG_STEP;
            base_mg = mobility_pkg::QUEEN_MG_BASE;
            step_eg = mobility_pkg::QUEEN_EG_STEP;
            base_eg = mobility_pkg::QUEEN_EG_BASE;
         end
         default: ;
      endcase
   end

   assign score_mg = step_mg * count_ext - base_mg;
   assign score_eg = step_eg * count_ext - base_eg;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         res_valid <= 1'b0;
         mobility  <= '0;
         eval_mg   <= '0;
         eval_eg   <= '0;
      end
      else
      begin
         res_valid <= exe_valid;
         if (exe_valid)   // Held until the next item
         begin
            mobility <= reach_count;
            eval_mg  <= exe_black ? -score_mg : score_mg;
            eval_eg  <= exe_black ? -score_eg : score_eg;
         end
      end
   end

endmodule

// File: verilog/ray_mobility.sv
////////////////////////////////////////////////////////////////////////////
// Execute stage: walks the sliding rays of the decoded piece and
// marks every square it can move to or capture on
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ray_mobility
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        dec_valid,
   input  mobility_pkg::piece_kind_t   dec_kind,
   input  logic                        dec_black,
   input  logic [5:0]                  dec_square,
   input  logic [63:0]                 dec_occupied,
   input  logic [63:0]                 dec_friendly,
   output logic                        exe_valid,
   output mobility_pkg::piece_kind_t   exe_kind,
   output logic                        exe_black,
   output logic [63:0]                 exe_reach
);

   logic        diag_en;    // Bishop or queen
   logic        orth_en;    // Rook or queen
   logic [7:0]  dir_en;
   logic [63:0] reach_c;

   // Directions 0..3 run along rows and columns, 4..7 along diagonals
   function automatic int row_step(input int dir);
      case (dir)
         0, 4, 5: row_step = 1;
         1, 6, 7: row_step = -1;
         default: row_step = 0;
      endcase
   endfunction

   function automatic int col_step(input int dir);
      case (dir)
         2, 4, 6: col_step = 1;
         3, 5, 7: col_step = -1;
         default: col_step = 0;
      endcase
   endfunction

   assign diag_en = (dec_kind == mobility_pkg::BISHOP) || (dec_kind == mobility_pkg::QUEEN);
   assign orth_en = (dec_kind == mobility_pkg::ROOK) || (dec_kind == mobility_pkg::QUEEN);
   assign dir_en  = {{4{diag_en}}, {4{orth_en}}};

   always_comb
   begin
      int         row;
      int         col;
      logic       open_ray;
      logic [5:0] idx;
      reach_c = '0;
      for (int d = 0; d < 8; d++)
      begin
         row      = int'(dec_square[5:3]);
         col      = int'(dec_square[2:0]);
         open_ray = dir_en[d];
         for (int s = 0; s < 7; s++)
         begin
            row = row + row_step(d);
            col = col + col_step(d);
            idx = {row[2:0], col[2:0]};
            if (open_ray && row >= 0 && row < 8 && col >= 0 && col < 8)
            begin
               if (!dec_occupied[idx])
                  reach_c[idx] = 1'b1;
               else
               begin
                  reach_c[idx] = !dec_friendly[idx];   // Capture only
                  open_ray     = 1'b0;
               end
            end
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         exe_valid <= 1'b0;
      else
         exe_valid <= dec_valid;
   end

   always_ff @(posedge clk)
   begin
      if (dec_valid)
      begin
         exe_kind  <= dec_kind;
         exe_black <= dec_black;
         exe_reach <= reach_c;
      end
   end

endmodule

// File: verilog/square_decode.sv
////////////////////////////////////////////////////////////////////////////
// Decode stage: picks the piece on the requested square and builds
// the occupancy and same-colour masks over the whole board
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module square_decode
(
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic                                  start,
   input  logic [mobility_pkg::BOARD_BITS-1:0]   board,
   input  logic [5:0]                            square,
   output logic                                  dec_valid,
   output mobility_pkg::piece_kind_t             dec_kind,
   output logic                                  dec_black,
   output logic [5:0]                            dec_square,
   output logic [63:0]                           dec_occupied,
   output logic [63:0]                           dec_friendly
);

   logic [mobility_pkg::SQUARE_BITS-1:0] code;   // Code of the selected piece
   logic [63:0]                          occupied_c;
   logic [63:0]                          friendly_c;

   assign code = board[square * mobility_pkg::SQUARE_BITS +: mobility_pkg::SQUARE_BITS];

   // A square is occupied when any of its four bits is set
   always_comb
   begin
      for (int i = 0; i < 64; i++)
      begin
         occupied_c[i] = |board[i * mobility_pkg::SQUARE_BITS +: mobility_pkg::SQUARE_BITS];
         friendly_c[i] = occupied_c[i] &&
                         (board[i * mobility_pkg::SQUARE_BITS + mobility_pkg::BLACK_BIT] ==
                          code[mobility_pkg::BLACK_BIT]);
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         dec_valid <= 1'b0;
      else
         dec_valid <= start;   // One cycle behind start
   end

   always_ff @(posedge clk)
   begin
      if (start)
      begin
         dec_kind     <= mobility_pkg::piece_kind_t'(code[2:0]);
         dec_black    <= code[mobility_pkg::BLACK_BIT];
         dec_square   <= square;
         dec_occupied <= occupied_c;
         dec_friendly <= friendly_c;
      end
   end

endmodule
